/* flist.f */
+incdir+sim
src/sb_pkg.sv
src/sb_interconnect.sv
src/sb_scratch_ram.sv
src/sb_gpio_regs.sv
src/sb_timer.sv
src/sb_subsystem_top.sv
sim/tb_sb_subsystem.sv

/* Makefile */
# Verilator build and run of the bus subsystem testbench

SRCS := $(shell grep -v '^+' flist.f)

obj_dir/Vtb_sb_subsystem: flist.f $(SRCS) sim/tb_sb_tasks.svh
	verilator --binary --timing -j 0 --timescale 1ns/10ps \
		--top-module tb_sb_subsystem -f flist.f

.PHONY: run clean

# Fails unless the pass line shows up in the output
run: obj_dir/Vtb_sb_subsystem
	@out="$$(./obj_dir/Vtb_sb_subsystem 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* sim/tb_sb_tasks.svh */
// Testbench bus tasks and models
`ifndef TB_SB_TASKS_SVH
`define TB_SB_TASKS_SVH

// Expected contents of the targets
logic [31:0]           ram_model [RAM_DEPTH];
logic [GPIO_WIDTH-1:0] gpio_model;
logic [31:0]           compare_model;

task automatic stop_with_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on the first error");
endtask

task automatic check_value(
    input string       name,
    input logic [31:0] actual,
    input logic [31:0] expected
);
    if (actual !== expected) begin
        $display("** Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
        stop_with_failure();
    end
endtask

task automatic clear_models();
    int i;
    for (i = 0; i < RAM_DEPTH; i++) begin
        ram_model[i] = '0;
    end
    gpio_model    = '0;
    compare_model = '0;
endtask

// Called on a falling edge, returns on one
task automatic wait_for_ready();
    while (host_rsp.ready !== 1'b1) begin
        @(negedge clock);
    end
endtask

task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    wait_for_ready();
    host_req.address      = addr;
    host_req.write_strobe = 1'b1;
    host_req.read_strobe  = 1'b0;
    host_req.write_data   = data;
    @(negedge clock);
    host_req = '0;
endtask

task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
    wait_for_ready();
    host_req.address      = addr;
    host_req.write_strobe = 1'b0;
    host_req.read_strobe  = 1'b1;
    host_req.write_data   = '0;
    @(negedge clock);
    host_req = '0;
    // Target registers at E+1, interconnect at E+2
    repeat (2) @(negedge clock);
    data = host_rsp.read_data;
endtask

// GPIO output register after one write
function automatic logic [GPIO_WIDTH-1:0] gpio_after_write(
    input logic [GPIO_WIDTH-1:0] current,
    input logic [1:0]            offset,
    input logic [GPIO_WIDTH-1:0] bits
);
    case (offset)
        GPIO_OUT: return bits;
        GPIO_SET: return current | bits;
        GPIO_CLR: return current & ~bits;
        default:  return current;
    endcase
endfunction

`endif

/* sim/tb_sb_subsystem.sv */
// Bus subsystem testbench
`timescale 1ns/10ps

module tb_sb_subsystem import sb_pkg::*; ();

    // Mirror of the default address map
    localparam logic [31:0] RAM_BASE    = 32'h0000_0000;
    localparam logic [31:0] RAM_LIMIT   = 32'h0000_0040;
    localparam logic [31:0] GPIO_BASE   = 32'h0000_0100;
    localparam logic [31:0] GPIO_LIMIT  = 32'h0000_0104;
    localparam logic [31:0] TIMER_BASE  = 32'h0000_0200;
    localparam logic [31:0] TIMER_LIMIT = 32'h0000_0204;
    localparam int          RAM_DEPTH   = 64;
    localparam int          RAM_AW      = $clog2(RAM_DEPTH);
    localparam int          GPIO_WIDTH  = 16;

    localparam int RESET_CYCLES = 10;
    localparam int RAM_OPS      = 100;
    localparam int GPIO_OPS     = 20;
    localparam int UNMAPPED_OPS = 10;

    // Run length budget doubled for the timeout
    localparam int ACCESS_COUNT   = 300;
    localparam int ACCESS_CYCLES  = 4;
    localparam int TIMER_WAIT     = 200;
    localparam int TIMEOUT_CYCLES =
        2 * (RAM_DEPTH + ACCESS_COUNT * ACCESS_CYCLES + TIMER_WAIT);

    logic                  clock;
    logic                  arst_n;
    sb_req_t               host_req;
    sb_rsp_t               host_rsp;
    logic [GPIO_WIDTH-1:0] gpio_in;
    logic [GPIO_WIDTH-1:0] gpio_out;
    logic                  timer_irq;
    logic [31:0]           rng_state;
    int                    cycle_count = 0;

    `include "tb_sb_tasks.svh"

    sb_subsystem_top #(
        .RAM_BASE    (RAM_BASE),
        .RAM_LIMIT   (RAM_LIMIT),
        .GPIO_BASE   (GPIO_BASE),
        .GPIO_LIMIT  (GPIO_LIMIT),
        .TIMER_BASE  (TIMER_BASE),
        .TIMER_LIMIT (TIMER_LIMIT),
        .RAM_DEPTH   (RAM_DEPTH),
        .GPIO_WIDTH  (GPIO_WIDTH)
    ) DUT (
        .clock     (clock),
        .arst_n    (arst_n),
        .host_req  (host_req),
        .host_rsp  (host_rsp),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .timer_irq (timer_irq)
    );

    // 4 ns clock period
    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            stop_with_failure();
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic in_any_window(input logic [31:0] addr);
        return ((addr >= RAM_BASE) && (addr < RAM_LIMIT))
            || ((addr >= GPIO_BASE) && (addr < GPIO_LIMIT))
            || ((addr >= TIMER_BASE) && (addr < TIMER_LIMIT));
    endfunction

    function automatic logic [31:0] random_unmapped_address();
        logic [31:0] addr;
        addr = next_random();
        // Most land just past a window limit
        case (addr[2:1])
            2'd0:    addr = RAM_LIMIT + {28'b0, addr[6:3]};
            2'd1:    addr = GPIO_LIMIT + {28'b0, addr[6:3]};
            2'd2:    addr = TIMER_LIMIT + {28'b0, addr[6:3]};
            default: addr = addr;
        endcase
        while (in_any_window(addr)) begin
            addr = next_random();
        end
        return addr;
    endfunction

    task automatic check_reset_and_clear();
        logic [31:0] data;
        int          waited;
        int          i;
        waited = 0;
        check_value("gpio_out", 32'(gpio_out), 32'h0);
        check_value("timer_irq", 32'(timer_irq), 32'h0);
        // RAM holds ready low while it zeroes itself
        while (!host_rsp.ready && (waited < RAM_DEPTH + 4)) begin
            @(negedge clock);
            waited++;
        end
        if (!host_rsp.ready) begin
            $display("host_rsp.ready stayed low for %0d cycles after reset", waited);
            stop_with_failure();
        end
        if (waited < RAM_DEPTH) begin
            $display("host_rsp.ready rose after %0d cycles, before the RAM clear ended",
                waited);
            stop_with_failure();
        end
        for (i = 0; i < RAM_DEPTH; i++) begin
            read_word(RAM_BASE + 32'(i), data);
            check_value($sformatf("host_rsp.read_data at 0x%08h", RAM_BASE + 32'(i)),
                data, 32'h0);
        end
    endtask

    task automatic ram_random_traffic();
        logic [31:0]       r;
        logic [31:0]       addr;
        logic [31:0]       data;
        logic [RAM_AW-1:0] index;
        repeat (RAM_OPS) begin
            r     = next_random();
            index = r[RAM_AW-1:0];
            addr  = RAM_BASE + 32'(index);
            if (r[8]) begin
                data = next_random();
                write_word(addr, data);
                ram_model[index] = data;
            end else begin
                read_word(addr, data);
                check_value($sformatf("host_rsp.read_data at 0x%08h", addr),
                    data, ram_model[index]);
            end
        end
    endtask

    task automatic gpio_set_clear_test();
        logic [31:0] data;
        logic [1:0]  offset;
        repeat (GPIO_OPS) begin
            offset = 2'(next_random() % 32'd3);
            data   = next_random();
            write_word(GPIO_BASE + 32'(offset), data);
            gpio_model = gpio_after_write(gpio_model, offset, data[GPIO_WIDTH-1:0]);
            // Output register lands one edge after the strobe
            @(negedge clock);
            check_value("gpio_out", 32'(gpio_out), 32'(gpio_model));
            read_word(GPIO_BASE + 32'(GPIO_OUT), data);
            check_value("host_rsp.read_data", data, 32'(gpio_model));
        end
        repeat (4) begin
            gpio_in = GPIO_WIDTH'(next_random());
            repeat (3) @(negedge clock);
            read_word(GPIO_BASE + 32'(GPIO_IN), data);
            check_value("host_rsp.read_data", data, 32'(gpio_in));
        end
    endtask

    task automatic unmapped_access_test();
        logic [31:0]       addr;
        logic [31:0]       data;
        logic [RAM_AW-1:0] index;
        // Timer holds a known compare value before the stray writes
        compare_model = next_random();
        write_word(TIMER_BASE + 32'(TMR_COMPARE), compare_model);
        repeat (UNMAPPED_OPS) begin
            addr = random_unmapped_address();
            read_word(addr, data);
            check_value($sformatf("host_rsp.read_data at 0x%08h", addr), data, 32'h0);
            addr = random_unmapped_address();
            write_word(addr, next_random());
        end
        @(negedge clock);
        check_value("gpio_out", 32'(gpio_out), 32'(gpio_model));
        check_value("timer_irq", 32'(timer_irq), 32'h0);
        read_word(GPIO_BASE + 32'(GPIO_OUT), data);
        check_value("host_rsp.read_data", data, 32'(gpio_model));
        read_word(TIMER_BASE + 32'(TMR_COMPARE), data);
        check_value("host_rsp.read_data", data, compare_model);
        read_word(TIMER_BASE + 32'(TMR_CTRL), data);
        check_value("host_rsp.read_data", data, 32'h0);
        repeat (8) begin
            index = RAM_AW'(next_random());
            read_word(RAM_BASE + 32'(index), data);
            check_value($sformatf("host_rsp.read_data at 0x%08h", RAM_BASE + 32'(index)),
                data, ram_model[index]);
        end
    endtask

    task automatic timer_compare_test();
        logic [31:0] data;
        int          waited;
        compare_model = 32'd8 + (next_random() % 32'd93);
        write_word(TIMER_BASE + 32'(TMR_COUNT), 32'h0);
        write_word(TIMER_BASE + 32'(TMR_COMPARE), compare_model);
        write_word(TIMER_BASE + 32'(TMR_CTRL), 32'h1);
        waited = 0;
        while (!timer_irq && (waited < int'(compare_model) + 4)) begin
            @(negedge clock);
            waited++;
        end
        if (!timer_irq) begin
            $display("timer_irq did not rise within %0d cycles of enabling", waited);
            stop_with_failure();
        end
        read_word(TIMER_BASE + 32'(TMR_COUNT), data);
        if (data > compare_model) begin
            $display("** Error: TMR_COUNT 0x%08h above TMR_COMPARE 0x%08h",
                data, compare_model);
            stop_with_failure();
        end
        // Clear lands before the counter reaches the compare value again
        write_word(TIMER_BASE + 32'(TMR_STATUS), 32'h1);
        @(negedge clock);
        check_value("timer_irq", 32'(timer_irq), 32'h0);
        read_word(TIMER_BASE + 32'(TMR_STATUS), data);
        check_value("host_rsp.read_data", data, 32'h0);
        write_word(TIMER_BASE + 32'(TMR_CTRL), 32'h0);
    endtask

    initial begin
        clock     = 1'b0;
        arst_n    = 1'b0;
        host_req  = '0;
        gpio_in   = '0;
        rng_state = 32'd96;
        clear_models();
        repeat (RESET_CYCLES) @(negedge clock);
        arst_n = 1'b1;
        check_reset_and_clear();
        ram_random_traffic();
        gpio_set_clear_test();
        unmapped_access_test();
        timer_compare_test();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* src/sb_subsystem_top.sv */
// Bus peripheral subsystem top
`timescale 1ns/10ps

module sb_subsystem_top import sb_pkg::*; #(
    parameter logic [31:0] RAM_BASE    = 32'h0000_0000,
    parameter logic [31:0] RAM_LIMIT   = 32'h0000_0040,
    parameter logic [31:0] GPIO_BASE   = 32'h0000_0100,
    parameter logic [31:0] GPIO_LIMIT  = 32'h0000_0104,
    parameter logic [31:0] TIMER_BASE  = 32'h0000_0200,
    parameter logic [31:0] TIMER_LIMIT = 32'h0000_0204,
    parameter int          RAM_DEPTH   = 64,
    parameter int          GPIO_WIDTH  = 16
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  sb_req_t               host_req,
    output sb_rsp_t               host_rsp,
    input  logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [GPIO_WIDTH-1:0] gpio_out,
    output logic                  timer_irq
);

    // Per target request and response
    sb_req_t ram_req;
    sb_req_t gpio_req;
    sb_req_t timer_req;
    sb_rsp_t ram_rsp;
    sb_rsp_t gpio_rsp;
    sb_rsp_t timer_rsp;

    sb_interconnect #(
        .RAM_BASE    (RAM_BASE),
        .RAM_LIMIT   (RAM_LIMIT),
        .GPIO_BASE   (GPIO_BASE),
        .GPIO_LIMIT  (GPIO_LIMIT),
        .TIMER_BASE  (TIMER_BASE),
        .TIMER_LIMIT (TIMER_LIMIT)
    ) u_interconnect (
        .clock     (clock),
        .arst_n    (arst_n),
        .host_req  (host_req),
        .host_rsp  (host_rsp),
        .ram_req   (ram_req),
        .gpio_req  (gpio_req),
        .timer_req (timer_req),
        .ram_rsp   (ram_rsp),
        .gpio_rsp  (gpio_rsp),
        .timer_rsp (timer_rsp)
    );

    sb_scratch_ram #(.RAM_DEPTH(RAM_DEPTH)) u_ram (
        .clock  (clock),
        .arst_n (arst_n),
        .req    (ram_req),
        .rsp    (ram_rsp)
    );

    sb_gpio_regs #(.GPIO_WIDTH(GPIO_WIDTH)) u_gpio (
        .clock    (clock),
        .arst_n   (arst_n),
        .req      (gpio_req),
        .rsp      (gpio_rsp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

    sb_timer u_timer (
        .clock  (clock),
        .arst_n (arst_n),
        .req    (timer_req),
        .rsp    (timer_rsp),
        .irq    (timer_irq)
    );

endmodule

/* src/sb_timer.sv */
// Compare timer bus target
`timescale 1ns/10ps

module sb_timer import sb_pkg::*; (
    input  logic    clock,
    input  logic    arst_n,
    input  sb_req_t req,
    output sb_rsp_t rsp,
    output logic    irq
);

    timer_reg_e  offset;
    logic        enable;
    logic [31:0] count;
    logic [31:0] compare;
    logic        match_flag;
    logic        hit;
    logic        clear_req;
    logic [31:0] rd_value;

    assign offset    = timer_reg_e'(req.address[1:0]);
    assign hit       = enable && (count == compare);
    assign clear_req = req.write_strobe && (offset == TMR_STATUS) && req.write_data[0];
    assign irq       = match_flag;

    // Control and compare registers
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            enable  <= 1'b0;
            compare <= '0;
        end else if (req.write_strobe) begin
            if (offset == TMR_CTRL) begin
                enable <= req.write_data[0];
            end
            if (offset == TMR_COMPARE) begin
                compare <= req.write_data;
            end
        end
    end

    // Counter, a bus write takes priority over counting
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (req.write_strobe && (offset == TMR_COUNT)) begin
            count <= req.write_data;
        end else if (hit) begin
            count <= '0;
        end else if (enable) begin
            count <= count + 32'd1;
        end
    end

    // Sticky match flag
    // a match in the same cycle as a clear keeps it set
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            match_flag <= 1'b0;
        end else if (hit) begin
            match_flag <= 1'b1;
        end else if (clear_req) begin
            match_flag <= 1'b0;
        end
    end

    always_comb begin
        case (offset)
            TMR_CTRL:    rd_value = {31'b0, enable};
            TMR_COUNT:   rd_value = count;
            TMR_COMPARE: rd_value = compare;
            TMR_STATUS:  rd_value = {31'b0, match_flag};
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rsp <= '0;
        end else begin
            rsp.ready     <= 1'b1;
            rsp.read_data <= req.read_strobe ? rd_value : '0;
        end
    end

endmodule

/* src/sb_gpio_regs.sv */
// GPIO register bus target
`timescale 1ns/10ps

module sb_gpio_regs import sb_pkg::*; #(
    parameter int GPIO_WIDTH = 16
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  sb_req_t               req,
    output sb_rsp_t               rsp,
    input  logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [GPIO_WIDTH-1:0] gpio_out
);

    gpio_reg_e             offset;
    logic [GPIO_WIDTH-1:0] out_q;
    logic [GPIO_WIDTH-1:0] in_meta;
    logic [GPIO_WIDTH-1:0] in_sync;
    logic [GPIO_WIDTH-1:0] wr_bits;
    logic [GPIO_WIDTH-1:0] rd_value;

    assign offset   = gpio_reg_e'(req.address[1:0]);
    assign wr_bits  = req.write_data[GPIO_WIDTH-1:0];
    assign gpio_out = out_q;

    // Only GPIO_IN reads the pins, the rest mirror the output
    assign rd_value = (offset == GPIO_IN) ? in_sync : out_q;

    // Two flop input synchronizer
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    // Output register with set and clear aliases
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_q <= '0;
        end else if (req.write_strobe) begin
            case (offset)
                GPIO_OUT: out_q <= wr_bits;
                GPIO_SET: out_q <= out_q | wr_bits;
                GPIO_CLR: out_q <= out_q & ~wr_bits;
                GPIO_IN:  out_q <= out_q;
            endcase
        end
    end

    // High bits above GPIO_WIDTH read as zero
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rsp <= '0;
        end else begin
            rsp.ready <= 1'b1;
            if (req.read_strobe) begin
                rsp.read_data <= 32'(rd_value);
            end else begin
                rsp.read_data <= '0;
            end
        end
    end

endmodule

/* src/sb_scratch_ram.sv */
// Scratch RAM bus target
`timescale 1ns/10ps

module sb_scratch_ram import sb_pkg::*; #(
    parameter int RAM_DEPTH = 64
) (
    input  logic    clock,
    input  logic    arst_n,
    input  sb_req_t req,
    output sb_rsp_t rsp
);

    localparam int ADDR_W = $clog2(RAM_DEPTH);

    ram_state_e        state;
    logic [ADDR_W-1:0] clear_addr;
    logic [ADDR_W-1:0] word_addr;
    logic [31:0]       mem [RAM_DEPTH];

    // Base is size aligned, low bits pick the word
    assign word_addr = req.address[ADDR_W-1:0];

    // Clear sequencer
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state      <= RAM_CLEAR;
            clear_addr <= '0;
        end else if (state == RAM_CLEAR) begin
            clear_addr <= clear_addr + ADDR_W'(1);
            if (clear_addr == ADDR_W'(RAM_DEPTH - 1)) begin
                state <= RAM_RUN;
            end
        end
    end

    // Storage
    always_ff @(posedge clock) begin
        if (state == RAM_CLEAR) begin
            mem[clear_addr] <= '0;
        end else if (req.write_strobe) begin
            mem[word_addr] <= req.write_data;
        end
    end

    // Read data lives for one cycle only
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rsp <= '0;
        end else begin
            rsp.ready <= (state == RAM_RUN);
            if ((state == RAM_RUN) && req.read_strobe) begin
                rsp.read_data <= mem[word_addr];
            end else begin
                rsp.read_data <= '0;
            end
        end
    end

endmodule

/* src/sb_interconnect.sv */
// Single master bus interconnect
`timescale 1ns/10ps

module sb_interconnect import sb_pkg::*; #(
    parameter logic [31:0] RAM_BASE    = 32'h0000_0000,
    parameter logic [31:0] RAM_LIMIT   = 32'h0000_0040,
    parameter logic [31:0] GPIO_BASE   = 32'h0000_0100,
    parameter logic [31:0] GPIO_LIMIT  = 32'h0000_0104,
    parameter logic [31:0] TIMER_BASE  = 32'h0000_0200,
    parameter logic [31:0] TIMER_LIMIT = 32'h0000_0204
) (
    input  logic    clock,
    input  logic    arst_n,
    input  sb_req_t host_req,
    output sb_rsp_t host_rsp,
    output sb_req_t ram_req,
    output sb_req_t gpio_req,
    output sb_req_t timer_req,
    input  sb_rsp_t ram_rsp,
    input  sb_rsp_t gpio_rsp,
    input  sb_rsp_t timer_rsp
);

    logic ram_hit;
    logic gpio_hit;
    logic timer_hit;

    // Base inclusive, limit exclusive
    function automatic logic in_window(
        input logic [31:0] addr,
        input logic [31:0] base,
        input logic [31:0] limit
    );
        return (addr >= base) && (addr < limit);
    endfunction

    // Pass the request on a hit, zeros otherwise
    function automatic sb_req_t route(input sb_req_t req, input logic hit);
        sb_req_t routed;
        routed = '0;
        if (hit) begin
            routed = req;
        end
        return routed;
    endfunction

    always_comb begin
        ram_hit   = in_window(host_req.address, RAM_BASE, RAM_LIMIT);
        gpio_hit  = in_window(host_req.address, GPIO_BASE, GPIO_LIMIT);
        timer_hit = in_window(host_req.address, TIMER_BASE, TIMER_LIMIT);
    end

    // Request path
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ram_req   <= '0;
            gpio_req  <= '0;
            timer_req <= '0;
        end else begin
            ram_req   <= route(host_req, ram_hit);
            gpio_req  <= route(host_req, gpio_hit);
            timer_req <= route(host_req, timer_hit);
        end
    end

    // Response path, idle targets return zero data so OR is safe
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            host_rsp <= '0;
        end else begin
            host_rsp.read_data <= ram_rsp.read_data | gpio_rsp.read_data
                                | timer_rsp.read_data;
            host_rsp.ready     <= ram_rsp.ready & gpio_rsp.ready & timer_rsp.ready;
        end
    end

endmodule

/* src/sb_pkg.sv */
// Simple bus shared types
package sb_pkg;

    // One bus request, routed from the master to a target
    typedef struct packed {
        // Word address
        logic [31:0] address;
        logic        write_strobe;
        logic        read_strobe;
        logic [31:0] write_data;
    } sb_req_t;

    // One bus response, returned by a target
    typedef struct packed {
        // Zero unless answering a read
        logic [31:0] read_data;
        logic        ready;
    } sb_rsp_t;

    // GPIO register offsets
    typedef enum logic [1:0] {
        GPIO_OUT = 2'd0,
        GPIO_SET = 2'd1,
        GPIO_CLR = 2'd2,
        // Read-only synchronized input
        GPIO_IN  = 2'd3
    } gpio_reg_e;

    // Timer register offsets
    typedef enum logic [1:0] {
        TMR_CTRL    = 2'd0,
        TMR_COUNT   = 2'd1,
        TMR_COMPARE = 2'd2,
        TMR_STATUS  = 2'd3
    } timer_reg_e;

    // Scratch RAM sequencing
    typedef enum logic {
        // Zeroing one word per cycle
        RAM_CLEAR = 1'b0,
        RAM_RUN   = 1'b1
    } ram_state_e;

endpackage
